// ==== hdl/lc3b_types.sv ====
package lc3b_types;

localparam int dmem_words = 256; // data RAM depth in words.

typedef logic [15:0] lc3b_word;
typedef logic [2:0] lc3b_reg;
typedef logic [2:0] lc3b_nzp; // n in bit 2, p in bit 0.

typedef enum logic [3:0] {
	op_br   = 4'b0000,
	op_add  = 4'b0001,
	op_ldb  = 4'b0010,
	op_stb  = 4'b0011,
	op_jsr  = 4'b0100,
	op_and  = 4'b0101,
	op_ldr  = 4'b0110,
	op_str  = 4'b0111,
	op_rti  = 4'b1000,
	op_not  = 4'b1001,
	op_ldi  = 4'b1010,
	op_sti  = 4'b1011,
	op_jmp  = 4'b1100,
	op_shf  = 4'b1101,
	op_lea  = 4'b1110,
	op_trap = 4'b1111
} lc3b_opcode;

typedef enum logic [2:0] {
	alu_add,
	alu_and,
	alu_not,
	alu_pass,
	alu_sll,
	alu_srl,
	alu_sra
} alu_ops;

typedef struct packed {
	lc3b_opcode opcode;
	logic load_regfile;
	logic [1:0] sr2mux_sel; // which extended field.
	logic sr2mux2_sel; // extended field instead of sr2.
	logic writemux_sel; // dest is r7.
	logic bradd2mux_sel; // target from base register.
	alu_ops aluop;
	logic alumux_sel; // trap vector into alu a.
	logic alu_forward;
	logic [1:0] newpcmux_sel;
	logic [2:0] regfilemux_sel;
	logic load_cc;
} lc3b_control_word;

typedef struct packed {
	lc3b_word pc;
	lc3b_word ir;
} fetch_pkt;

// decode to execute.
typedef struct packed {
	lc3b_word pc;
	lc3b_word ir;
	lc3b_control_word ctrl;
} dx_pkt;

// execute to writeback.
typedef struct packed {
	lc3b_reg dest;
	lc3b_word alu_out;
	lc3b_word link;
	lc3b_word lea_addr;
	logic load_regfile;
	logic load_cc;
	logic [2:0] regfilemux_sel;
	logic byte_sel; // low address bit for byte loads.
} xw_pkt;

endpackage : lc3b_types

// ==== hdl/control_rom.sv ====
`timescale 1ns/1ps

module control_rom import lc3b_types::*; (
	input lc3b_opcode opcode,
	input logic ir4,
	input logic ir5,
	input logic ir11,
	output lc3b_control_word ctrl
);

always_comb begin
	// every opcode starts from these defaults.
	ctrl.opcode = opcode;
	ctrl.load_regfile = 1'b0;
	ctrl.sr2mux_sel = 2'b00;
	ctrl.sr2mux2_sel = 1'b0;
	ctrl.writemux_sel = 1'b0;
	ctrl.bradd2mux_sel = 1'b0;
	ctrl.aluop = alu_pass;
	ctrl.alumux_sel = 1'b0;
	ctrl.alu_forward = 1'b0;
	ctrl.newpcmux_sel = 2'b00;
	ctrl.regfilemux_sel = 3'b000;
	ctrl.load_cc = 1'b0;

	case (opcode)
		op_add: begin
			if (ir5) begin // imm5 form.
				ctrl.sr2mux_sel = 2'b10;
				ctrl.sr2mux2_sel = 1'b1;
			end
			ctrl.aluop = alu_add;
			ctrl.alu_forward = 1'b1;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end

		op_and: begin
			if (ir5) begin
				ctrl.sr2mux_sel = 2'b10;
				ctrl.sr2mux2_sel = 1'b1;
			end
			ctrl.aluop = alu_and;
			ctrl.alu_forward = 1'b1;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end

		op_not: begin
			ctrl.aluop = alu_not;
			ctrl.alu_forward = 1'b1;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end

		op_shf: begin
			ctrl.sr2mux_sel = 2'b11; // amount from imm4.
			ctrl.sr2mux2_sel = 1'b1;
			if (!ir4)
				ctrl.aluop = alu_sll;
			else if (!ir5)
				ctrl.aluop = alu_srl;
			else
				ctrl.aluop = alu_sra;
			ctrl.alu_forward = 1'b1;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end

		op_br: begin
			ctrl.newpcmux_sel = 2'b01; // conditional on nzp.
		end

		op_jmp: begin
			ctrl.bradd2mux_sel = 1'b1;
		end

		op_jsr: begin
			ctrl.writemux_sel = 1'b1; // link goes to r7.
			ctrl.regfilemux_sel = 3'b010;
			ctrl.load_regfile = 1'b1;
			if (!ir11)
				ctrl.bradd2mux_sel = 1'b1; // jsrr.
		end

		op_ldr: begin
			// base plus word offset.
			ctrl.sr2mux2_sel = 1'b1;
			ctrl.aluop = alu_add;
			ctrl.regfilemux_sel = 3'b001;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end

		op_str: begin
			ctrl.sr2mux2_sel = 1'b1;
			ctrl.aluop = alu_add;
		end

		op_ldb: begin
			// unscaled offset, byte zero extended.
			ctrl.sr2mux_sel = 2'b01;
			ctrl.sr2mux2_sel = 1'b1;
			ctrl.aluop = alu_add;
			ctrl.regfilemux_sel = 3'b100;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end

		op_stb: begin
			ctrl.sr2mux_sel = 2'b01;
			ctrl.sr2mux2_sel = 1'b1;
			ctrl.aluop = alu_add;
		end

		op_lea: begin
			ctrl.regfilemux_sel = 3'b011;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end

		op_trap: begin
			ctrl.writemux_sel = 1'b1;
			ctrl.regfilemux_sel = 3'b010;
			ctrl.load_regfile = 1'b1;
			ctrl.alumux_sel = 1'b1; // vector address through alu.
			ctrl.newpcmux_sel = 2'b10;
		end

		op_ldi: begin
			ctrl.sr2mux2_sel = 1'b1;
			ctrl.aluop = alu_add;
			ctrl.regfilemux_sel = 3'b001;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end

		op_sti: begin
			ctrl.sr2mux2_sel = 1'b1;
			ctrl.aluop = alu_add;
		end

		default: begin
			ctrl = '0; // rti and anything undefined.
		end
	endcase
end

endmodule : control_rom

// ==== hdl/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
	parameter type payload_t = logic [15:0]
) (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input payload_t in_data,
	output logic out_valid,
	output payload_t out_data
);

always_ff @(posedge clk) begin
	if (!rst_n)
		out_valid <= 1'b0;
	else
		out_valid <= in_valid;
end

always_ff @(posedge clk) begin
	if (in_valid)
		out_data <= in_data; // holds while the stage is idle.
end

a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
	!$isunknown(out_valid))
	else $error("pipe_reg out_valid is unknown");

endmodule : pipe_reg

// ==== hdl/regfile.sv ====
`timescale 1ns/1ps

module regfile import lc3b_types::*; (
	input logic clk,
	input logic rst_n,
	input logic load,
	input lc3b_reg dest,
	input lc3b_word in,
	input lc3b_reg src_a,
	input lc3b_reg src_b,
	input lc3b_reg src_c,
	output lc3b_word a,
	output lc3b_word b,
	output lc3b_word c
);

lc3b_word regs [8];

always_ff @(posedge clk) begin
	if (!rst_n) begin
		for (int i = 0; i < 8; i++)
			regs[i] <= '0;
	end else if (load) begin
		regs[dest] <= in;
	end
end

// reads are combinational.
assign a = regs[src_a];
assign b = regs[src_b];
assign c = regs[src_c]; // store source.

endmodule : regfile

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu import lc3b_types::*; (
	input alu_ops aluop,
	input lc3b_word a,
	input lc3b_word b,
	output lc3b_word f
);

logic [3:0] shamt;

assign shamt = b[3:0]; // only the low nibble counts.

always_comb begin
	case (aluop)
		alu_add: f = a + b;
		alu_and: f = a & b;
		alu_not: f = ~a;
		alu_pass: f = a;
		alu_sll: f = a << shamt;
		alu_srl: f = a >> shamt;
		alu_sra: f = lc3b_word'($signed(a) >>> shamt); // sign fill.
		default: f = '0;
	endcase
end

// aluop must be one of the seven defined encodings.
always_comb begin
	a_aluop_defined: assert (aluop inside {alu_add, alu_and, alu_not, alu_pass,
		alu_sll, alu_srl, alu_sra})
		else $error("alu received undefined aluop %b", aluop);
end

endmodule : alu

// ==== hdl/data_mem.sv ====
`timescale 1ns/1ps

module data_mem import lc3b_types::*; (
	input logic clk,
	input logic write,
	input logic write_byte,
	input lc3b_word address,
	input lc3b_word wdata,
	output lc3b_word rdata
);

lc3b_word mem [dmem_words];
logic [7:0] index;

assign index = address[8:1]; // word address.

initial begin
	for (int i = 0; i < dmem_words; i++)
		mem[i] = '0;
end

always_ff @(posedge clk) begin
	if (write) begin
		if (!write_byte)
			mem[index] <= wdata;
		else if (address[0])
			mem[index][15:8] <= wdata[7:0]; // odd byte is the upper half.
		else
			mem[index][7:0] <= wdata[7:0];
	end
	rdata <= mem[index]; // old data on a same-cycle write.
end

// word stores need an even address.
a_word_aligned: assert property (@(posedge clk)
	write && !write_byte |-> !address[0])
	else $error("word write to odd address %h", address);

endmodule : data_mem

// ==== hdl/lc3b_core.sv ====
`timescale 1ns/1ps

module lc3b_core import lc3b_types::*; (
	input logic clk,
	input logic rst_n,
	input logic instr_valid,
	input fetch_pkt instr,
	output logic wb_valid,
	output lc3b_reg wb_dest,
	output lc3b_word wb_data,
	output lc3b_nzp cc,
	output logic redirect_valid,
	output lc3b_word redirect_pc
);

lc3b_control_word ctrl_dec;
dx_pkt dx_in, x;
xw_pkt xw_in, w;
logic x_valid, w_valid;
lc3b_word rf_a, rf_b, rf_c, sr1, sr2, sr3;
lc3b_word ext, alu_a, alu_b, alu_out, pc_next, target, dmem_rdata;
lc3b_word imm5, offs6, imm4, offs9_sh, offs11_sh, trap_addr;
lc3b_nzp wb_nzp, cc_x;
logic br_taken, take_redirect, mem_write;

// decode.
control_rom rom (.opcode(lc3b_opcode'(instr.ir[15:12])), .ir4(instr.ir[4]),
	.ir5(instr.ir[5]), .ir11(instr.ir[11]), .ctrl(ctrl_dec));

assign dx_in = '{pc: instr.pc, ir: instr.ir, ctrl: ctrl_dec};

pipe_reg #(.payload_t(dx_pkt)) dx_reg (.clk(clk), .rst_n(rst_n), .in_valid(instr_valid),
	.in_data(dx_in), .out_valid(x_valid), .out_data(x));

// execute.
regfile rf (.clk(clk), .rst_n(rst_n), .load(wb_valid), .dest(wb_dest), .in(wb_data),
	.src_a(x.ir[8:6]), .src_b(x.ir[2:0]), .src_c(x.ir[11:9]),
	.a(rf_a), .b(rf_b), .c(rf_c));

// writeback result bypasses the register file.
assign sr1 = (wb_valid && wb_dest == x.ir[8:6]) ? wb_data : rf_a;
assign sr2 = (wb_valid && wb_dest == x.ir[2:0]) ? wb_data : rf_b;
assign sr3 = (wb_valid && wb_dest == x.ir[11:9]) ? wb_data : rf_c;

assign imm5 = {{11{x.ir[4]}}, x.ir[4:0]};
assign offs6 = {{10{x.ir[5]}}, x.ir[5:0]};
assign imm4 = {12'h000, x.ir[3:0]};
assign offs9_sh = {{6{x.ir[8]}}, x.ir[8:0], 1'b0};
assign offs11_sh = {{4{x.ir[10]}}, x.ir[10:0], 1'b0};
assign trap_addr = {7'b0, x.ir[7:0], 1'b0};
assign pc_next = x.pc + 16'd2;

always_comb begin
	case (x.ctrl.sr2mux_sel)
		2'b00: ext = offs6 << 1;
		2'b01: ext = offs6;
		2'b10: ext = imm5;
		default: ext = imm4;
	endcase
	alu_b = x.ctrl.sr2mux2_sel ? ext : sr2;
	alu_a = x.ctrl.alumux_sel ? trap_addr : sr1;
end

alu alu_i (.aluop(x.ctrl.aluop), .a(alu_a), .b(alu_b), .f(alu_out));

assign mem_write = x_valid && (x.ctrl.opcode inside {op_str, op_stb});

data_mem dmem (.clk(clk), .write(mem_write), .write_byte(x.ctrl.opcode == op_stb),
	.address(alu_out), .wdata(sr3), .rdata(dmem_rdata));

// branch sees the cc that writeback is about to commit.
assign cc_x = (w_valid && w.load_cc) ? wb_nzp : cc;
assign br_taken = (x.ctrl.newpcmux_sel == 2'b01) && |(x.ir[11:9] & cc_x);
assign take_redirect = br_taken || (x.ctrl.opcode inside {op_jmp, op_jsr});
assign target = x.ctrl.bradd2mux_sel ? sr1 :
	pc_next + ((x.ctrl.opcode == op_jsr) ? offs11_sh : offs9_sh);

always_comb begin
	xw_in.dest = x.ctrl.writemux_sel ? 3'd7 : x.ir[11:9];
	xw_in.alu_out = alu_out;
	xw_in.link = pc_next;
	xw_in.lea_addr = pc_next + offs9_sh;
	xw_in.load_regfile = x.ctrl.load_regfile;
	xw_in.load_cc = x.ctrl.load_cc;
	xw_in.regfilemux_sel = x.ctrl.regfilemux_sel;
	xw_in.byte_sel = alu_out[0];
end

pipe_reg #(.payload_t(xw_pkt)) xw_reg (.clk(clk), .rst_n(rst_n), .in_valid(x_valid),
	.in_data(xw_in), .out_valid(w_valid), .out_data(w));

always_ff @(posedge clk) begin
	if (!rst_n)
		redirect_valid <= 1'b0;
	else
		redirect_valid <= x_valid && take_redirect; // one-cycle pulse.
end

always_ff @(posedge clk) begin
	if (x_valid && take_redirect)
		redirect_pc <= target;
end

// writeback.
always_comb begin
	case (w.regfilemux_sel)
		3'b001: wb_data = dmem_rdata;
		3'b010: wb_data = w.link;
		3'b011: wb_data = w.lea_addr;
		3'b100: wb_data = {8'h00, w.byte_sel ? dmem_rdata[15:8] : dmem_rdata[7:0]};
		default: wb_data = w.alu_out;
	endcase
end

assign wb_valid = w_valid && w.load_regfile;
assign wb_dest = w.dest;
assign wb_nzp = {wb_data[15], wb_data == '0, !wb_data[15] && wb_data != '0};

always_ff @(posedge clk) begin
	if (!rst_n)
		cc <= 3'b010; // z after reset.
	else if (w_valid && w.load_cc)
		cc <= wb_nzp;
end

endmodule : lc3b_core

// ==== bench/lc3b_model.svh ====
`ifndef LC3B_MODEL_SVH
`define LC3B_MODEL_SVH

lc3b_word m_rf [8]; // architectural registers.
lc3b_word m_mem [dmem_words];
lc3b_nzp m_cc = 3'b010;
logic [31:0] lfsr = 32'hefa8_ec93;

// one galois step per bit taken.
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		r = {r[30:0], lfsr[0]};
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
	end
	return r;
endfunction

function automatic lc3b_word enc_rrr(lc3b_opcode op, lc3b_reg d, lc3b_reg s1, lc3b_reg s2);
	return {op, d, s1, 3'b000, s2};
endfunction

function automatic lc3b_word enc_imm(lc3b_opcode op, lc3b_reg d, lc3b_reg s1, logic [4:0] imm);
	return {op, d, s1, 1'b1, imm};
endfunction

// kind is {ir5, ir4}.
function automatic lc3b_word enc_shf(lc3b_reg d, lc3b_reg s, logic [1:0] kind, logic [3:0] amt);
	return {op_shf, d, s, kind, amt};
endfunction

function automatic lc3b_word enc_mem(lc3b_opcode op, lc3b_reg r, lc3b_reg base, logic [5:0] off);
	return {op, r, base, off};
endfunction

task automatic model_exec(input lc3b_word pc, input lc3b_word ir, output logic wbv,
	output lc3b_reg dest, output lc3b_word res, output logic ccl, output logic rv,
	output lc3b_word rpc);
	lc3b_word s1, b, addr, off9, link;
	s1 = m_rf[ir[8:6]];
	b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : m_rf[ir[2:0]];
	addr = s1 + ((ir[15:12] inside {op_ldr, op_str}) ?
		{{9{ir[5]}}, ir[5:0], 1'b0} : {{10{ir[5]}}, ir[5:0]});
	off9 = {{6{ir[8]}}, ir[8:0], 1'b0};
	link = pc + 16'd2;
	{wbv, ccl, rv, rpc, res} = '0;
	dest = ir[11:9];
	case (lc3b_opcode'(ir[15:12]))
		op_add: {wbv, ccl, res} = {2'b11, s1 + b};
		op_and: {wbv, ccl, res} = {2'b11, s1 & b};
		op_not: {wbv, ccl, res} = {2'b11, ~s1};
		op_shf: begin
			{wbv, ccl} = 2'b11;
			if (!ir[4])
				res = s1 << ir[3:0];
			else if (!ir[5])
				res = s1 >> ir[3:0];
			else begin
				res = s1 >> ir[3:0];
				if (s1[15])
					res = res | ~(16'hffff >> ir[3:0]); // vacated bits take the sign.
			end
		end
		op_ldr: {wbv, ccl, res} = {2'b11, m_mem[addr[8:1]]};
		op_ldb: {wbv, ccl, res} = {2'b11, 8'h00,
			addr[0] ? m_mem[addr[8:1]][15:8] : m_mem[addr[8:1]][7:0]};
		op_str: m_mem[addr[8:1]] = m_rf[ir[11:9]];
		op_stb: begin
			if (addr[0])
				m_mem[addr[8:1]][15:8] = m_rf[ir[11:9]][7:0];
			else
				m_mem[addr[8:1]][7:0] = m_rf[ir[11:9]][7:0];
		end
		op_lea: {wbv, ccl, res} = {2'b11, link + off9};
		op_jsr: begin
			{wbv, rv, dest, res} = {2'b11, 3'd7, link};
			rpc = ir[11] ? link + {{4{ir[10]}}, ir[10:0], 1'b0} : s1;
		end
		op_jmp: {rv, rpc} = {1'b1, s1};
		op_br: if (|(ir[11:9] & m_cc)) {rv, rpc} = {1'b1, link + off9};
		default: ;
	endcase
	if (wbv)
		m_rf[dest] = res;
	if (ccl)
		m_cc = res[15] ? 3'b100 : (res == '0) ? 3'b010 : 3'b001;
endtask

`endif

// ==== bench/lc3b_core_tb.sv ====
`timescale 1ns/1ps

module lc3b_core_tb import lc3b_types::*; ();

logic clk = 1'b0;
logic rst_n, instr_valid;
fetch_pkt instr;
logic wb_valid, redirect_valid;
lc3b_reg wb_dest, exp_dest;
lc3b_word wb_data, redirect_pc, exp_data, exp_rpc, next_pc;
lc3b_nzp cc, exp_cc;
logic exp_wbv, exp_rv;
int cyc = 0;
lc3b_reg dest_at [int];
lc3b_word data_at [int], rpc_at [int];
lc3b_nzp cc_at [int];

`include "lc3b_model.svh"

lc3b_core uut (.clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
	.wb_valid(wb_valid), .wb_dest(wb_dest), .wb_data(wb_data), .cc(cc),
	.redirect_valid(redirect_valid), .redirect_pc(redirect_pc));

always #4 clk = ~clk;

always @(posedge clk) cyc <= cyc + 1;

// expected outputs for the coming edge.
always @(negedge clk) begin
	exp_wbv = data_at.exists(cyc + 1);
	exp_dest = exp_wbv ? dest_at[cyc + 1] : '0;
	exp_data = exp_wbv ? data_at[cyc + 1] : '0;
	exp_rv = rpc_at.exists(cyc + 1);
	exp_rpc = exp_rv ? rpc_at[cyc + 1] : '0;
	if (cc_at.exists(cyc + 1))
		exp_cc = cc_at[cyc + 1];
end

task automatic report_mismatch(input string name, input lc3b_word exp, input lc3b_word act);
	$display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
	$display("Simulation finished: FAIL");
	$fatal(1, "mismatch on %s", name);
endtask

a_wb_valid: assert property (@(posedge clk) disable iff (!rst_n) wb_valid == exp_wbv)
	else report_mismatch("wb_valid", 16'(exp_wbv), 16'($sampled(wb_valid)));
a_wb_dest: assert property (@(posedge clk) disable iff (!rst_n) exp_wbv |-> wb_dest == exp_dest)
	else report_mismatch("wb_dest", 16'(exp_dest), 16'($sampled(wb_dest)));
a_wb_data: assert property (@(posedge clk) disable iff (!rst_n) exp_wbv |-> wb_data == exp_data)
	else report_mismatch("wb_data", exp_data, $sampled(wb_data));
a_redirect: assert property (@(posedge clk) disable iff (!rst_n) redirect_valid == exp_rv)
	else report_mismatch("redirect_valid", 16'(exp_rv), 16'($sampled(redirect_valid)));
a_redirect_pc: assert property (@(posedge clk) disable iff (!rst_n)
	exp_rv |-> redirect_pc == exp_rpc)
	else report_mismatch("redirect_pc", exp_rpc, $sampled(redirect_pc));
a_cc: assert property (@(posedge clk) disable iff (!rst_n) cc == exp_cc)
	else report_mismatch("cc", 16'(exp_cc), 16'($sampled(cc)));

// strobe one instruction and book its results two and three edges out.
task automatic issue(input lc3b_word ir, input int gap);
	logic wbv, ccl, rv;
	lc3b_reg d;
	lc3b_word res, rpc;
	int k;
	@(negedge clk);
	k = cyc + 1;
	instr_valid = 1'b1;
	instr = '{pc: next_pc, ir: ir};
	model_exec(next_pc, ir, wbv, d, res, ccl, rv, rpc);
	if (wbv) begin
		dest_at[k + 2] = d;
		data_at[k + 2] = res;
	end
	if (rv)
		rpc_at[k + 2] = rpc;
	if (ccl)
		cc_at[k + 3] = m_cc;
	next_pc = next_pc + 16'd2;
	repeat (gap) begin
		@(negedge clk);
		instr_valid = 1'b0;
	end
endtask

function automatic int rand_gap();
	return int'(rand_bits(2));
endfunction

function automatic lc3b_reg rand_reg();
	return lc3b_reg'(rand_bits(3));
endfunction

function automatic lc3b_word rand_alu();
	case (rand_bits(3))
		0, 1: return enc_rrr(op_add, rand_reg(), rand_reg(), rand_reg());
		2, 3: return enc_imm(op_add, rand_reg(), rand_reg(), 5'(rand_bits(5)));
		4: return enc_rrr(op_and, rand_reg(), rand_reg(), rand_reg());
		5: return enc_imm(op_and, rand_reg(), rand_reg(), 5'(rand_bits(5)));
		default: return {op_not, rand_reg(), rand_reg(), 6'h3f};
	endcase
endfunction

initial begin
	int n_instr;
	n_instr = 16 + 40 + 60 + 105 + 79 + 30 + 70; // instructions issued below.
	#((n_instr * 40 + 16) * 8 * 1ns);
	$display("timeout: the core stopped producing results in time");
	$display("Simulation finished: FAIL");
	$fatal(1, "watchdog expired");
end

initial begin
	rst_n = 1'b0;
	instr_valid = 1'b0;
	instr = '0;
	next_pc = 16'h3000;
	exp_cc = 3'b010;
	for (int i = 0; i < 8; i++)
		m_rf[i] = '0;
	for (int i = 0; i < dmem_words; i++)
		m_mem[i] = '0;
	repeat (16) @(negedge clk);
	rst_n = 1'b1;
	for (int r = 0; r < 8; r++) begin // seed registers.
		issue(enc_imm(op_and, lc3b_reg'(r), lc3b_reg'(r), 5'h00), rand_gap());
		issue(enc_imm(op_add, lc3b_reg'(r), lc3b_reg'(r), 5'(rand_bits(5))), rand_gap());
	end
	repeat (40) issue(rand_alu(), rand_gap());
	repeat (60) issue(rand_alu(), 0); // back to back, all forwarded.
	for (int k = 0; k < 3; k++) begin
		issue(enc_imm(op_and, 3'd1, 3'd1, 5'h00), 0);
		issue(enc_imm(op_add, 3'd1, 3'd1, 5'h0b), 0);
		issue({op_not, 3'd1, 3'd1, 6'h3f}, 0); // negative source.
		for (int a = 0; a < 16; a++) begin
			issue(enc_shf(3'd2, 3'd1, (k == 0) ? 2'b00 : (k == 1) ? 2'b01 : 2'b11, 4'(a)), 0);
			issue(enc_shf(3'd3, rand_reg(), (k == 0) ? 2'b00 : (k == 1) ? 2'b01 : 2'b11,
				4'(a)), rand_gap());
		end
	end
	issue(enc_imm(op_and, 3'd6, 3'd6, 5'h00), 0); // even base in r6.
	issue(enc_imm(op_add, 3'd6, 3'd6, 5'h0f), 0);
	issue(enc_rrr(op_add, 3'd6, 3'd6, 3'd6), 0);
	for (int i = 0; i < 19; i++) begin
		logic [5:0] off;
		off = 6'(rand_bits(6));
		issue(enc_mem(op_str, rand_reg(), 3'd6, off), rand_gap());
		issue(enc_mem(op_ldr, lc3b_reg'(rand_bits(2)), 3'd6, off), rand_gap());
		off = 6'(rand_bits(6));
		issue(enc_mem(op_stb, rand_reg(), 3'd6, off), rand_gap());
		issue(enc_mem(op_ldb, lc3b_reg'(rand_bits(2)), 3'd6, off), rand_gap());
	end
	for (int i = 0; i < 10; i++) begin
		issue({op_lea, rand_reg(), 9'(rand_bits(9))}, rand_gap());
		issue({op_jsr, 1'b1, 11'(rand_bits(11))}, rand_gap());
		issue({op_jsr, 3'b000, rand_reg(), 6'h00}, rand_gap()); // jsrr.
	end
	for (int i = 0; i < 30; i++) begin
		issue(rand_alu(), 0);
		issue({op_br, 3'(rand_bits(3)), 9'(rand_bits(9))}, rand_gap());
	end
	repeat (10) issue({op_jmp, 3'b000, rand_reg(), 6'h00}, rand_gap());
	@(negedge clk);
	instr_valid = 1'b0;
	repeat (6) @(negedge clk); // drain the pipeline.
	$display("Simulation finished: PASS");
	$finish;
end

endmodule : lc3b_core_tb

// ==== verilog.f ====
hdl/lc3b_types.sv
hdl/control_rom.sv
hdl/pipe_reg.sv
hdl/regfile.sv
hdl/alu.sv
hdl/data_mem.sv
hdl/lc3b_core.sv
+incdir+bench
bench/lc3b_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= lc3b_core_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only -f $(FILELIST) --top-module lc3b_core

clean:
	rm -rf $(BUILD_DIR) $(LOG)
